// File: all.f
+incdir+rtl
rtl/lane_status_pkg.sv
rtl/lane_event_encoder.sv
rtl/status_synchronizer.sv
rtl/lane_health_tracker.sv
rtl/lane_status_monitor.sv
verification/tb_clock_gen.sv
verification/lane_status_monitor_tb.sv

// File: rtl/lane_event_encoder.sv
//////////////////////////////////////////////////
// lane-side capture ahead of the clock crossing
// one instance per lane, clocked by that lane's recovered clock
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lane_event_encoder (
	input  wire logic                        lane_clk,
	input  wire logic                        lane_arst,
	input  wire lane_status_pkg::lane_status_t lane_status,
	output      lane_status_pkg::lane_status_t encoded
);

	//////////////////////////////////////////////////
	// launch flops for the crossing

	// every bit leaves from a flop so the far side never
	// samples combinational glitches from the lane logic
	always_ff @(posedge lane_clk or posedge lane_arst) begin
		if (lane_arst) begin
			encoded <= '0;
		end else begin
			// steady levels pass straight through
			encoded.word_locked <= lane_status.word_locked;
			encoded.sync_locked <= lane_status.sync_locked;

			// pulses fold into toggles
			// each event flips its bit once, so a one-cycle pulse
			// becomes a level change the common side can't miss
			encoded.framing_error <=
				encoded.framing_error ^ lane_status.framing_error;
			encoded.crc32_error <=
				encoded.crc32_error ^ lane_status.crc32_error;
			encoded.scrambler_mismatch <=
				encoded.scrambler_mismatch ^ lane_status.scrambler_mismatch;
			encoded.missing_sync <=
				encoded.missing_sync ^ lane_status.missing_sync;
		end
	end

endmodule

`default_nettype wire

// File: rtl/lane_health_tracker.sv
//////////////////////////////////////////////////
// common-side interpretation of synchronized lane status
// lock aggregation, crc32 tallies and sticky error flags
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lane_status_params.svh"

module lane_health_tracker (
	input  wire logic                                       common_clk,
	input  wire logic                                       common_arst,
	input  wire logic                                       status_clear,
	input  wire lane_status_pkg::sync_status_t              s_status,
	output      logic                                       all_word_locked,
	output      logic                                       all_sync_locked,
	output      logic [`LSM_LANES-1:0][`LSM_CNT_W-1:0]      crc32_err_cntrs,
	output      logic [`LSM_LANES-1:0]                      framing_sticky,
	output      logic [`LSM_LANES-1:0]                      scrambler_sticky,
	output      logic [`LSM_LANES-1:0]                      missing_sync_sticky
);

	localparam int LN = `LSM_LANES;

	// clear mask, all lanes at once
	logic [LN-1:0] keep;

	assign keep = {LN{~status_clear}};

	//////////////////////////////////////////////////
	// link-wide lock flags

	always_ff @(posedge common_clk or posedge common_arst) begin
		if (common_arst) begin
			all_word_locked <= 1'b0;
			all_sync_locked <= 1'b0;
		end else begin
			all_word_locked <= &s_status.word_locked;
			all_sync_locked <= &s_status.sync_locked;
		end
	end

	//////////////////////////////////////////////////
	// crc32 error tally per lane

	// free-running, wraps at 2**LSM_CNT_W
	// status_clear leaves these alone
	always_ff @(posedge common_clk or posedge common_arst) begin
		if (common_arst) begin
			crc32_err_cntrs <= '0;
		end else begin
			for (int i = 0; i < LN; i++) begin
				if (s_status.crc32_error[i]) begin
					crc32_err_cntrs[i] <= crc32_err_cntrs[i] + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// sticky flags for the remaining error kinds

	// a pulse in the same cycle as the clear still sets the flag
	always_ff @(posedge common_clk or posedge common_arst) begin
		if (common_arst) begin
			framing_sticky      <= '0;
			scrambler_sticky    <= '0;
			missing_sync_sticky <= '0;
		end else begin
			framing_sticky      <= (framing_sticky & keep) | s_status.framing_error;
			scrambler_sticky    <= (scrambler_sticky & keep) | s_status.scrambler_mismatch;
			missing_sync_sticky <= (missing_sync_sticky & keep) | s_status.missing_sync;
		end
	end

	// aggregate lock only follows a cycle where every lane was locked
	a_word_lock_agg : assert property (
		@(posedge common_clk) disable iff (common_arst)
		all_word_locked |-> $past(&s_status.word_locked)
	);

	// tallies move only on a crc32 pulse from the cycle before
	for (genvar g = 0; g < LN; g++) begin : g_cnt_chk
		a_cnt_needs_pulse : assert property (
			@(posedge common_clk) disable iff (common_arst)
			$changed(crc32_err_cntrs[g]) |-> $past(s_status.crc32_error[g])
		);
	end

endmodule

`default_nettype wire

// File: rtl/lane_status_monitor.sv
//////////////////////////////////////////////////
// lane status monitor top, one status word per lane clock in,
// synchronized status plus lock, tally and sticky results out
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lane_status_params.svh"

module lane_status_monitor (
	input  wire logic [`LSM_LANES-1:0]                          lane_clk,
	input  wire logic [`LSM_LANES-1:0]                          lane_arst,
	input  wire lane_status_pkg::lane_status_t [`LSM_LANES-1:0] lane_status,
	input  wire logic                                           common_clk,
	input  wire logic                                           common_arst,
	input  wire logic                                           status_clear,
	output      lane_status_pkg::sync_status_t                  s_status,
	output      logic                                           all_word_locked,
	output      logic                                           all_sync_locked,
	output      logic [`LSM_LANES-1:0][`LSM_CNT_W-1:0]          crc32_err_cntrs,
	output      logic [`LSM_LANES-1:0]                          framing_sticky,
	output      logic [`LSM_LANES-1:0]                          scrambler_sticky,
	output      logic [`LSM_LANES-1:0]                          missing_sync_sticky
);

	import lane_status_pkg::*;

	// launch flops, one word per lane in its own clock domain
	lane_status_t [`LSM_LANES-1:0] encoded;

	//////////////////////////////////////////////////
	// lane side

	for (genvar g = 0; g < `LSM_LANES; g++) begin : g_lane
		lane_event_encoder u_enc (
			.lane_clk    (lane_clk[g]),
			.lane_arst   (lane_arst[g]),
			.lane_status (lane_status[g]),
			.encoded     (encoded[g])
		);
	end

	//////////////////////////////////////////////////
	// common side

	status_synchronizer u_sync (
		.common_clk  (common_clk),
		.common_arst (common_arst),
		.encoded     (encoded),
		.s_status    (s_status)
	);

	lane_health_tracker u_track (
		.common_clk          (common_clk),
		.common_arst         (common_arst),
		.status_clear        (status_clear),
		.s_status            (s_status),
		.all_word_locked     (all_word_locked),
		.all_sync_locked     (all_sync_locked),
		.crc32_err_cntrs     (crc32_err_cntrs),
		.framing_sticky      (framing_sticky),
		.scrambler_sticky    (scrambler_sticky),
		.missing_sync_sticky (missing_sync_sticky)
	);

endmodule

`default_nettype wire

// File: rtl/lane_status_params.svh
//////////////////////////////////////////////////
// sizing macros for the lane status monitor
// include wherever lane count, sync depth or counter width is needed
//////////////////////////////////////////////////

`ifndef LANE_STATUS_PARAMS_SVH
`define LANE_STATUS_PARAMS_SVH

// number of receive lanes watched
`define LSM_LANES 4

// flops per crossing chain, keep at 2 or more
`define LSM_SYNC_STAGES 3

// width of each per-lane crc32 error tally, wraps on overflow
`define LSM_CNT_W 8

`endif

// File: rtl/lane_status_pkg.sv
//////////////////////////////////////////////////
// status word types shared by the lane status monitor
// lane side uses lane_status_t, common side uses sync_status_t
//////////////////////////////////////////////////

`default_nettype none

`include "lane_status_params.svh"

package lane_status_pkg;

	// one lane's status, on that lane's clock
	// raw input: two levels then four one-cycle pulses
	// encoder output: same layout, event bits hold toggle states
	typedef struct packed {
		logic word_locked;
		logic sync_locked;
		logic framing_error;
		logic crc32_error;
		logic scrambler_mismatch;
		logic missing_sync;
	} lane_status_t;

	// all lanes seen from the common clock
	// event fields are single common-cycle pulses here
	typedef struct packed {
		logic [`LSM_LANES-1:0] word_locked;
		logic [`LSM_LANES-1:0] sync_locked;
		logic [`LSM_LANES-1:0] framing_error;
		logic [`LSM_LANES-1:0] crc32_error;
		logic [`LSM_LANES-1:0] scrambler_mismatch;
		logic [`LSM_LANES-1:0] missing_sync;
	} sync_status_t;

endpackage

`default_nettype wire

// File: rtl/status_synchronizer.sv
//////////////////////////////////////////////////
// common-clock synchronizer chains for every lane
// recovers lock levels and turns toggles back into one-cycle pulses
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lane_status_params.svh"

module status_synchronizer (
	input  wire logic                                        common_clk,
	input  wire logic                                        common_arst,
	input  wire lane_status_pkg::lane_status_t [`LSM_LANES-1:0] encoded,
	output      lane_status_pkg::sync_status_t                 s_status
);

	localparam int LN  = `LSM_LANES;
	localparam int STG = `LSM_SYNC_STAGES;

	// row index of each kind inside the chain arrays
	localparam int LV_WORD      = 0;
	localparam int LV_SYNC      = 1;
	localparam int EV_FRAMING   = 0;
	localparam int EV_CRC32     = 1;
	localparam int EV_SCRAMBLER = 2;
	localparam int EV_MISSING   = 3;

	// lane bits regrouped by kind
	logic [1:0][LN-1:0] lvl_in;
	logic [3:0][LN-1:0] evt_in;

	// stage 0 is the first capture flop
	logic [STG-1:0][1:0][LN-1:0] lvl_c;
	// one extra stage on events for the edge detect
	logic [STG:0][3:0][LN-1:0]   evt_c;

	logic [3:0][LN-1:0] evt_out;

	//////////////////////////////////////////////////
	// regroup per-lane words into per-kind vectors

	always_comb begin
		for (int i = 0; i < LN; i++) begin
			lvl_in[LV_WORD][i]      = encoded[i].word_locked;
			lvl_in[LV_SYNC][i]      = encoded[i].sync_locked;
			evt_in[EV_FRAMING][i]   = encoded[i].framing_error;
			evt_in[EV_CRC32][i]     = encoded[i].crc32_error;
			evt_in[EV_SCRAMBLER][i] = encoded[i].scrambler_mismatch;
			evt_in[EV_MISSING][i]   = encoded[i].missing_sync;
		end
	end

	//////////////////////////////////////////////////
	// crossing chains

	// first stage may go metastable, later stages settle it
	always_ff @(posedge common_clk or posedge common_arst) begin
		if (common_arst) begin
			lvl_c <= '0;
			evt_c <= '0;
		end else begin
			lvl_c <= {lvl_c[STG-2:0], lvl_in};
			evt_c <= {evt_c[STG-1:0], evt_in};
		end
	end

	// a toggle change shows up as a mismatch between the last two stages
	assign evt_out = evt_c[STG] ^ evt_c[STG-1];

	assign s_status = '{
		word_locked:        lvl_c[STG-1][LV_WORD],
		sync_locked:        lvl_c[STG-1][LV_SYNC],
		framing_error:      evt_out[EV_FRAMING],
		crc32_error:        evt_out[EV_CRC32],
		scrambler_mismatch: evt_out[EV_SCRAMBLER],
		missing_sync:       evt_out[EV_MISSING]
	};

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the lane status monitor testbench with Verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=lsm_sim

verilator --binary --assert --timescale 1ns/100ps \
	--top-module lane_status_monitor_tb -f all.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
else
	exit 1
fi

// File: verification/lane_status_monitor_tb.sv
//////////////////////////////////////////////////
// testbench for the lane status monitor
// replays scenario lines from the vectors file and checks the results
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lane_status_params.svh"

module lane_status_monitor_tb;

	import lane_status_pkg::*;

	localparam int LN          = `LSM_LANES;
	localparam int COMMON_PER  = 40;
	localparam int LANE_PER    = 48;
	localparam int SETTLE      = 20;
	localparam int MAX_VECS    = 64;
	// words per scenario line, inputs then expected values
	localparam int REC_W       = 11 + 2 * LN;
	localparam string VEC_FILE = "verification/lane_status_vectors.txt";

	wire                      common_clk;
	wire                      common_arst;
	wire [LN-1:0]             lane_clk;
	wire [LN-1:0]             lane_arst;
	wire lane_status_t [LN-1:0] lane_status;
	wire [LN-1:0]             lane_busy;
	logic                     status_clear;

	sync_status_t                   s_status;
	logic                           all_word_locked;
	logic                           all_sync_locked;
	logic [LN-1:0][`LSM_CNT_W-1:0] crc32_err_cntrs;
	logic [LN-1:0]                  framing_sticky;
	logic [LN-1:0]                  scrambler_sticky;
	logic [LN-1:0]                  missing_sync_sticky;

	// word 0 holds the scenario count
	logic [15:0] vec_mem [0:MAX_VECS*REC_W];

	// per-lane burst requests, read by the lane drivers
	int          crc_req [LN];
	logic [LN-1:0] wl_req;
	logic [LN-1:0] sl_req;
	logic [LN-1:0] frm_req;
	logic [LN-1:0] scr_req;
	logic [LN-1:0] mis_req;
	event        start_burst;

	int error_count;
	int check_count;
	int vec_count;
	int max_burst;
	int cycle_count;
	int cycle_limit = 1000000;

	tb_clock_gen #(
		.PERIOD_NS    (COMMON_PER),
		.PHASE_NS     (0),
		.RESET_CYCLES (2)
	) u_common_clk (
		.clk  (common_clk),
		.arst (common_arst)
	);

	//////////////////////////////////////////////////
	// lane drivers, one per lane clock

	// odd phase offsets keep lane edges off the common edges
	for (genvar g = 0; g < LN; g++) begin : g_lane
		lane_status_t drv;
		logic         busy;
		int           n_cyc;

		tb_clock_gen #(
			.PERIOD_NS    (LANE_PER),
			.PHASE_NS     (3 + 8 * g),
			.RESET_CYCLES (2)
		) u_lane_clk (
			.clk  (lane_clk[g]),
			.arst (lane_arst[g])
		);

		assign lane_status[g] = drv;
		assign lane_busy[g]   = busy;

		initial begin
			drv  = '0;
			busy = 1'b0;
			forever begin
				@(start_burst);
				busy = 1'b1;
				@(negedge lane_clk[g]);
				drv.word_locked = wl_req[g];
				drv.sync_locked = sl_req[g];
				// crc pulses back to back, other kinds ride on the first cycle
				n_cyc = (crc_req[g] > 0) ? crc_req[g] : 1;
				for (int k = 0; k < n_cyc; k++) begin
					drv.crc32_error        = (k < crc_req[g]);
					drv.framing_error      = (k == 0) && frm_req[g];
					drv.scrambler_mismatch = (k == 0) && scr_req[g];
					drv.missing_sync       = (k == 0) && mis_req[g];
					@(negedge lane_clk[g]);
				end
				drv.crc32_error        = 1'b0;
				drv.framing_error      = 1'b0;
				drv.scrambler_mismatch = 1'b0;
				drv.missing_sync       = 1'b0;
				busy = 1'b0;
			end
		end
	end

	lane_status_monitor UUT (
		.lane_clk            (lane_clk),
		.lane_arst           (lane_arst),
		.lane_status         (lane_status),
		.common_clk          (common_clk),
		.common_arst         (common_arst),
		.status_clear        (status_clear),
		.s_status            (s_status),
		.all_word_locked     (all_word_locked),
		.all_sync_locked     (all_sync_locked),
		.crc32_err_cntrs     (crc32_err_cntrs),
		.framing_sticky      (framing_sticky),
		.scrambler_sticky    (scrambler_sticky),
		.missing_sync_sticky (missing_sync_sticky)
	);

	//////////////////////////////////////////////////
	// helpers

	task automatic check_value(input string name, input int expv, input int actv);
		check_count++;
		assert (actv == expv) else begin
			error_count++;
			$display("MISMATCH %s expected %0h actual %0h", name, expv, actv);
		end
	endtask

	// one common cycle of clear, driven between rising edges
	task automatic pulse_clear();
		@(negedge common_clk);
		status_clear = 1'b1;
		@(negedge common_clk);
		status_clear = 1'b0;
	endtask

	task automatic run_vector(input int v);
		int    base;
		string tag;
		base = 1 + v * REC_W;
		tag  = $sformatf("vec%0d", v);
		wl_req  = vec_mem[base + 1][LN-1:0];
		sl_req  = vec_mem[base + 2][LN-1:0];
		for (int i = 0; i < LN; i++) begin
			crc_req[i] = int'(vec_mem[base + 3 + i]);
		end
		frm_req = vec_mem[base + 3 + LN][LN-1:0];
		scr_req = vec_mem[base + 4 + LN][LN-1:0];
		mis_req = vec_mem[base + 5 + LN][LN-1:0];
		if (vec_mem[base] != 16'h0) begin
			pulse_clear();
		end
		-> start_burst;
		@(negedge common_clk);
		wait (lane_busy == '0);
		// let the last toggles cross and reach the tracker
		repeat (SETTLE) @(negedge common_clk);
		for (int i = 0; i < LN; i++) begin
			check_value($sformatf("%s crc32 count lane %0d", tag, i),
				int'(vec_mem[base + 6 + LN + i]), int'(crc32_err_cntrs[i]));
		end
		check_value({tag, " framing sticky"}, int'(vec_mem[base + 6 + 2*LN]),
			int'(framing_sticky));
		check_value({tag, " scrambler sticky"}, int'(vec_mem[base + 7 + 2*LN]),
			int'(scrambler_sticky));
		check_value({tag, " missing sync sticky"}, int'(vec_mem[base + 8 + 2*LN]),
			int'(missing_sync_sticky));
		check_value({tag, " all word locked"}, int'(vec_mem[base + 9 + 2*LN]),
			int'(all_word_locked));
		check_value({tag, " all sync locked"}, int'(vec_mem[base + 10 + 2*LN]),
			int'(all_sync_locked));
		// levels pass through unchanged, no event still in flight
		check_value({tag, " sync word lock"}, int'(wl_req), int'(s_status.word_locked));
		check_value({tag, " sync sync lock"}, int'(sl_req), int'(s_status.sync_locked));
		check_value({tag, " sync events idle"}, 0,
			int'({s_status.framing_error, s_status.crc32_error,
				s_status.scrambler_mismatch, s_status.missing_sync}));
	endtask

	//////////////////////////////////////////////////
	// main sequence

	initial begin
		status_clear = 1'b0;
		wl_req       = '0;
		sl_req       = '0;
		frm_req      = '0;
		scr_req      = '0;
		mis_req      = '0;
		error_count  = 0;
		check_count  = 0;
		for (int i = 0; i < LN; i++) begin
			crc_req[i] = 0;
		end
		$readmemh(VEC_FILE, vec_mem);
		vec_count = int'(vec_mem[0]);
		if (vec_count < 1 || vec_count > MAX_VECS) begin
			error_count++;
			$display("vector file gave an unusable scenario count of %0d", vec_count);
			vec_count = 0;
		end
		// run length bound from the longest crc burst
		max_burst = 1;
		for (int v = 0; v < vec_count; v++) begin
			for (int i = 0; i < LN; i++) begin
				if (int'(vec_mem[1 + v * REC_W + 3 + i]) > max_burst) begin
					max_burst = int'(vec_mem[1 + v * REC_W + 3 + i]);
				end
			end
		end
		cycle_limit = vec_count * (max_burst * 2 + SETTLE) + 100;
		wait (common_arst == 1'b0 && lane_arst == '0);
		repeat (2) @(negedge common_clk);
		for (int v = 0; v < vec_count; v++) begin
			run_vector(v);
		end
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// watchdog on the common clock
	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge common_clk);
			cycle_count++;
		end
		$display("timeout after %0d common cycles, lanes never went idle", cycle_count);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/lane_status_vectors.txt
// first word is the scenario count, then one scenario per line, masks hold lane 0 in bit 0
// clr wl sl crc0 crc1 crc2 crc3 frm scr mis | cnt0 cnt1 cnt2 cnt3 frm scr mis all_wl all_sl
000c
0 0 0 000 000 000 000 0 0 0  00 00 00 00 0 0 0 0 0
0 7 f 000 000 000 000 0 0 0  00 00 00 00 0 0 0 0 1
0 f f 000 000 000 000 0 0 0  00 00 00 00 0 0 0 1 1
0 f f 000 005 001 000 0 0 0  00 05 01 00 0 0 0 1 1
0 f e 000 000 000 00c 0 0 0  00 05 01 0c 0 0 0 1 0
0 f f 12c 000 000 000 0 0 0  2c 05 01 0c 0 0 0 1 1
0 f f 000 000 000 000 2 8 1  2c 05 01 0c 2 8 1 1 1
0 f f 000 000 000 000 4 0 0  2c 05 01 0c 6 8 1 1 1
1 0 f 000 000 000 000 0 0 0  2c 05 01 0c 0 0 0 0 1
0 f f 003 003 003 003 f f f  2f 08 04 0f f f f 1 1
1 0 0 001 000 000 000 1 0 0  30 08 04 0f 1 0 0 0 0
1 0 0 000 000 000 000 0 0 0  30 08 04 0f 0 0 0 0 0

// File: verification/tb_clock_gen.sv
//////////////////////////////////////////////////
// testbench clock and reset source
// one instance per clock domain, reset held for a few cycles
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int PHASE_NS     = 0,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst
);

	// phase offset delays the first edge only
	initial begin
		clk = 1'b0;
		#(PHASE_NS);
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		arst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst = 1'b0;
	end

endmodule

`default_nettype wire
